//--- source/mist_pkg.sv
// mist support package: shared widths, SPI command codes, video structs and core id
`default_nettype none

package mist_pkg;

   typedef logic [3:0]  rgb4_t;     // native game color channel
   typedef logic [5:0]  rgb6_t;     // connector / scan doubler channel
   typedef logic [31:0] word32_t;
   typedef logic [21:0] rom_addr_t;
   typedef logic [7:0]  byte_t;

   // bit events from the synchronized SPI pins
   typedef struct packed {
      logic bit_rise;
      logic bit_fall;
      logic sdi;
   } spi_ev_t;

   typedef struct packed {
      rgb4_t nat_r;
      rgb4_t nat_g;
      rgb4_t nat_b;
      logic  nat_hs;
      logic  nat_vs;
      rgb6_t dbl_r;   // scan-doubled video
      rgb6_t dbl_g;
      rgb6_t dbl_b;
      logic  dbl_hs;
      logic  dbl_vs;
   } video_in_t;

   typedef struct packed {
      rgb6_t r;
      rgb6_t g;
      rgb6_t b;
      logic  hs;
      logic  vs;
   } video_out_t;

   typedef struct packed {
      logic scan2x_dis;
      logic ypbpr;
   } vid_cfg_t;

   localparam byte_t CMD_JOY0     = 8'h01;
   localparam byte_t CMD_JOY1     = 8'h02;
   localparam byte_t CMD_STATUS   = 8'h1E;
   localparam byte_t CMD_VIDCFG   = 8'h14;
   localparam byte_t CMD_DL_START = 8'h54;
   localparam byte_t CMD_DL_END   = 8'h55;
   localparam byte_t CMD_DL_DATA  = 8'h56;
   localparam byte_t CORE_ID      = 8'hA4;

endpackage

`default_nettype wire

//--- source/spi_front.sv
// SPI front end: brings SCK, DI and both selects into clk_sys and makes bit events
`default_nettype none
`timescale 1ns/1ps

module spi_front (
   input  wire               clk_sys,
   input  wire               rst_n_i,
   input  wire               spi_sck_i,
   input  wire               spi_di_i,
   input  wire               spi_ss_io_i,
   input  wire               spi_ss_dl_i,
   output mist_pkg::spi_ev_t spi_ev_o,
   output logic              sel_io_o,
   output logic              sel_dl_o
);

   logic [1:0] sck_q;
   logic [1:0] di_q;
   logic [1:0] ss_io_q;
   logic [1:0] ss_dl_q;
   logic       sck_prev_q;   // edge flop

   always_ff @(posedge clk_sys or negedge rst_n_i) begin
      if (!rst_n_i) begin
         sck_q      <= 2'b00;
         di_q       <= 2'b00;
         ss_io_q    <= 2'b11;   // selects idle high
         ss_dl_q    <= 2'b11;
         sck_prev_q <= 1'b0;
      end else begin
         sck_q      <= {sck_q[0], spi_sck_i};
         di_q       <= {di_q[0], spi_di_i};
         ss_io_q    <= {ss_io_q[0], spi_ss_io_i};
         ss_dl_q    <= {ss_dl_q[0], spi_ss_dl_i};
         sck_prev_q <= sck_q[1];
      end
   end

   assign spi_ev_o.bit_rise = sck_q[1] & ~sck_prev_q;
   assign spi_ev_o.bit_fall = ~sck_q[1] & sck_prev_q;
   assign spi_ev_o.sdi      = di_q[1];   // aligned with the sck stage
   assign sel_io_o          = ss_io_q[1];
   assign sel_dl_o          = ss_dl_q[1];

endmodule

`default_nettype wire

//--- source/spi_user_io.sv
// SPI user IO: decodes joystick, status and video option commands, returns the core id
`default_nettype none
`timescale 1ns/1ps

module spi_user_io (
   input  wire               clk_sys,
   input  wire               rst_n_i,
   input  wire               mist_pkg::spi_ev_t spi_ev_i,
   input  wire               sel_i,          // active low
   output logic              spi_do_o,
   output mist_pkg::word32_t joystick1_o,
   output mist_pkg::word32_t joystick2_o,
   output mist_pkg::word32_t status_o,
   output mist_pkg::vid_cfg_t vid_cfg_o
);

   import mist_pkg::*;

   logic [2:0] bit_cnt;
   logic [6:0] shift_q;
   logic [2:0] byte_idx;    // 0 is the command, saturates at 5
   byte_t      cmd_q;
   word32_t    word_q;
   byte_t      do_sr;       // core id going out
   byte_t      rx_byte;
   logic       byte_done;
   logic       wr_word_q;
   logic       wr_cfg_q;

   assign rx_byte   = {shift_q, spi_ev_i.sdi};
   assign byte_done = spi_ev_i.bit_rise & ~sel_i & (bit_cnt == 3'd7);
   assign spi_do_o  = ~sel_i & (byte_idx == 3'd0) & do_sr[7];

   // byte and word assembly
   always_ff @(posedge clk_sys) begin
      if (spi_ev_i.bit_rise && !sel_i) shift_q <= rx_byte[6:0];
      if (byte_done) word_q <= {word_q[23:0], rx_byte};   // msb first
   end

   always_ff @(posedge clk_sys or negedge rst_n_i) begin
      if (!rst_n_i) begin
         bit_cnt     <= '0;
         byte_idx    <= '0;
         cmd_q       <= '0;
         do_sr       <= CORE_ID;
         wr_word_q   <= 1'b0;
         wr_cfg_q    <= 1'b0;
         joystick1_o <= '0;
         joystick2_o <= '0;
         status_o    <= '0;
         vid_cfg_o   <= '0;
      end else begin
         wr_word_q <= byte_done & (byte_idx == 3'd4);
         wr_cfg_q  <= byte_done & (byte_idx == 3'd1);
         if (sel_i) begin   // deselect drops any partial byte
            bit_cnt  <= '0;
            byte_idx <= '0;
            do_sr    <= CORE_ID;
         end else begin
            if (spi_ev_i.bit_rise) bit_cnt <= bit_cnt + 3'd1;
            if (spi_ev_i.bit_fall && byte_idx == 3'd0) do_sr <= {do_sr[6:0], 1'b0};
            if (byte_done) begin
               if (byte_idx == 3'd0) cmd_q <= rx_byte;
               if (byte_idx != 3'd5) byte_idx <= byte_idx + 3'd1;
            end
         end
         if (wr_word_q) begin
            case (cmd_q)
               CMD_JOY0:   joystick1_o <= word_q;
               CMD_JOY1:   joystick2_o <= word_q;
               CMD_STATUS: status_o    <= word_q;
               default:    ;
            endcase
         end
         if (wr_cfg_q && cmd_q == CMD_VIDCFG) begin
            vid_cfg_o.scan2x_dis <= word_q[0];
            vid_cfg_o.ypbpr      <= word_q[1];
         end
      end
   end

   // the front end must never report both SCK edges at once
   a_one_edge: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
      !(spi_ev_i.bit_rise && spi_ev_i.bit_fall));

endmodule

`default_nettype wire

//--- source/spi_rom_loader.sv
// SPI ROM loader: turns download transactions into an address, data and write stream
`default_nettype none
`timescale 1ns/1ps

module spi_rom_loader (
   input  wire                 clk_sys,
   input  wire                 rst_n_i,
   input  wire                 mist_pkg::spi_ev_t spi_ev_i,
   input  wire                 sel_i,          // active low
   output logic                downloading_o,
   output mist_pkg::rom_addr_t ioctl_addr_o,
   output mist_pkg::byte_t     ioctl_data_o,
   output logic                ioctl_wr_o
);

   import mist_pkg::*;

   logic [2:0] bit_cnt;
   logic [6:0] shift_q;
   logic       cmd_phase;   // next byte is a command
   byte_t      cmd_q;
   byte_t      rx_byte;
   logic       byte_done;
   logic       data_byte;

   assign rx_byte   = {shift_q, spi_ev_i.sdi};
   assign byte_done = spi_ev_i.bit_rise & ~sel_i & (bit_cnt == 3'd7);
   assign data_byte = byte_done & ~cmd_phase & (cmd_q == CMD_DL_DATA) & downloading_o;

   always_ff @(posedge clk_sys) begin
      if (spi_ev_i.bit_rise && !sel_i) shift_q <= rx_byte[6:0];
      if (data_byte) ioctl_data_o <= rx_byte;
   end

   always_ff @(posedge clk_sys or negedge rst_n_i) begin
      if (!rst_n_i) begin
         bit_cnt       <= '0;
         cmd_phase     <= 1'b1;
         cmd_q         <= '0;
         downloading_o <= 1'b0;
         ioctl_addr_o  <= '0;
         ioctl_wr_o    <= 1'b0;
      end else begin
         ioctl_wr_o <= data_byte;   // one cycle per byte
         if (ioctl_wr_o) ioctl_addr_o <= ioctl_addr_o + 1'b1;
         if (sel_i) begin
            bit_cnt   <= '0;
            cmd_phase <= 1'b1;
         end else begin
            if (spi_ev_i.bit_rise) bit_cnt <= bit_cnt + 3'd1;
            if (byte_done && cmd_phase) begin
               cmd_phase <= 1'b0;
               cmd_q     <= rx_byte;
               if (rx_byte == CMD_DL_START) begin
                  downloading_o <= 1'b1;
                  ioctl_addr_o  <= '0;
               end
               if (rx_byte == CMD_DL_END) downloading_o <= 1'b0;
            end
         end
      end
   end

   // a write strobe only follows a byte taken inside a download
   a_wr_in_dl: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
      ioctl_wr_o |-> downloading_o);

endmodule

`default_nettype wire

//--- source/video_out_stage.sv
// video output stage: source select, optional YPbPr conversion, registered connector pins
`default_nettype none
`timescale 1ns/1ps

module video_out_stage (
   input  wire                  clk_sys,
   input  wire                  rst_n_i,
   input  wire                  mist_pkg::video_in_t vid_i,
   input  wire                  mist_pkg::vid_cfg_t cfg_i,
   output mist_pkg::video_out_t vid_o
);

   import mist_pkg::*;

   rgb6_t             src_r;
   rgb6_t             src_g;
   rgb6_t             src_b;
   logic              src_hs;
   logic              src_vs;
   logic              csync;
   logic signed [15:0] r_s;
   logic signed [15:0] g_s;
   logic signed [15:0] b_s;
   logic signed [15:0] y_sum;
   logic signed [15:0] pb_sum;
   logic signed [15:0] pr_sum;
   logic signed [15:0] pb_full;
   logic signed [15:0] pr_full;
   video_out_t        nxt;

   always_comb begin
      if (cfg_i.scan2x_dis) begin   // native video, widened
         src_r  = {vid_i.nat_r, vid_i.nat_r[3:2]};
         src_g  = {vid_i.nat_g, vid_i.nat_g[3:2]};
         src_b  = {vid_i.nat_b, vid_i.nat_b[3:2]};
         src_hs = ~vid_i.nat_hs;
         src_vs = ~vid_i.nat_vs;
      end else begin
         src_r  = vid_i.dbl_r;
         src_g  = vid_i.dbl_g;
         src_b  = vid_i.dbl_b;
         src_hs = vid_i.dbl_hs;
         src_vs = vid_i.dbl_vs;
      end
      csync = ~(src_hs ^ src_vs);
   end

   // RGB to YPbPr, coefficients scaled by 256
   always_comb begin
      r_s     = $signed({10'd0, src_r});
      g_s     = $signed({10'd0, src_g});
      b_s     = $signed({10'd0, src_b});
      y_sum   = 16'sd77 * r_s + 16'sd150 * g_s + 16'sd29 * b_s;
      pb_sum  = 16'sd128 * b_s - 16'sd43 * r_s - 16'sd85 * g_s;
      pr_sum  = 16'sd128 * r_s - 16'sd107 * g_s - 16'sd21 * b_s;
      pb_full = 16'sd32 + (pb_sum >>> 8);
      pr_full = 16'sd32 + (pr_sum >>> 8);
   end

   always_comb begin
      if (cfg_i.ypbpr) begin
         nxt.r = pr_full[5:0];
         nxt.g = y_sum[13:8];
         nxt.b = pb_full[5:0];
      end else begin
         nxt.r = src_r;
         nxt.g = src_g;
         nxt.b = src_b;
      end
      // scart cables want csync on hs and a high vs
      nxt.hs = (cfg_i.scan2x_dis | cfg_i.ypbpr) ? csync : src_hs;
      nxt.vs = (cfg_i.scan2x_dis | cfg_i.ypbpr) ? 1'b1 : src_vs;
   end

   always_ff @(posedge clk_sys or negedge rst_n_i) begin
      if (!rst_n_i) vid_o <= '0;
      else          vid_o <= nxt;
   end

endmodule

`default_nettype wire

//--- source/sd_audio_dac.sv
// audio DAC: first-order sigma-delta modulator giving one output bit per clock
`default_nettype none
`timescale 1ns/1ps

module sd_audio_dac #(
   parameter bit SIGNED_SND = 1'b0   // 1 for two's complement samples
) (
   input  wire        clk_sys,
   input  wire        rst_n_i,
   input  wire [15:0] snd_i,
   output logic       snd_pwm_o
);

   logic [15:0] sample;
   logic [15:0] acc_q;
   logic [16:0] sum;

   // msb flip turns two's complement into offset binary
   assign sample = {snd_i[15] ^ SIGNED_SND, snd_i[14:0]};
   assign sum    = {1'b0, acc_q} + {1'b0, sample};

   always_ff @(posedge clk_sys or negedge rst_n_i) begin
      if (!rst_n_i) begin
         acc_q     <= '0;
         snd_pwm_o <= 1'b0;
      end else begin
         acc_q     <= sum[15:0];
         snd_pwm_o <= sum[16];   // carry is the density bit
      end
   end

endmodule

`default_nettype wire

//--- source/mist_base.sv
// MiST base: SPI config and ROM download, video connector conditioning and audio DAC
`default_nettype none
`timescale 1ns/1ps

module mist_base #(
   parameter bit SIGNED_SND = 1'b0
) (
   input  wire                      clk_sys,
   input  wire                      rst_n_i,
   // native and scan-doubled video
   input  wire mist_pkg::rgb4_t     game_r_i,
   input  wire mist_pkg::rgb4_t     game_g_i,
   input  wire mist_pkg::rgb4_t     game_b_i,
   input  wire                      hs_i,
   input  wire                      vs_i,
   input  wire mist_pkg::rgb6_t     scan2x_r_i,
   input  wire mist_pkg::rgb6_t     scan2x_g_i,
   input  wire mist_pkg::rgb6_t     scan2x_b_i,
   input  wire                      scan2x_hs_i,
   input  wire                      scan2x_vs_i,
   output wire                      scan2x_enb_o,   // scan doubler disable
   output wire mist_pkg::rgb6_t     video_r_o,
   output wire mist_pkg::rgb6_t     video_g_o,
   output wire mist_pkg::rgb6_t     video_b_o,
   output wire                      video_hs_o,
   output wire                      video_vs_o,
   // SPI from the controller chip
   output wire                      spi_do_o,
   input  wire                      spi_di_i,
   input  wire                      spi_sck_i,
   input  wire                      spi_ss2_i,
   input  wire                      conf_data0_i,
   output wire mist_pkg::word32_t   status_o,
   output wire mist_pkg::word32_t   joystick1_o,
   output wire mist_pkg::word32_t   joystick2_o,
   // sound
   input  wire [15:0]               snd_i,
   output wire                      snd_pwm_o,
   // ROM download
   output wire mist_pkg::rom_addr_t ioctl_addr_o,
   output wire mist_pkg::byte_t     ioctl_data_o,
   output wire                      ioctl_wr_o,
   output wire                      downloading_o
);

   import mist_pkg::*;

   spi_ev_t    spi_ev;
   logic       sel_io;
   logic       sel_dl;
   vid_cfg_t   vid_cfg;
   video_in_t  vid_in;
   video_out_t vid_out;

   assign vid_in = '{nat_r: game_r_i, nat_g: game_g_i, nat_b: game_b_i,
                     nat_hs: hs_i, nat_vs: vs_i,
                     dbl_r: scan2x_r_i, dbl_g: scan2x_g_i, dbl_b: scan2x_b_i,
                     dbl_hs: scan2x_hs_i, dbl_vs: scan2x_vs_i};

   assign scan2x_enb_o = vid_cfg.scan2x_dis;
   assign video_r_o    = vid_out.r;
   assign video_g_o    = vid_out.g;
   assign video_b_o    = vid_out.b;
   assign video_hs_o   = vid_out.hs;
   assign video_vs_o   = vid_out.vs;

   spi_front u_spi_front (
      .clk_sys     ( clk_sys      ),
      .rst_n_i     ( rst_n_i      ),
      .spi_sck_i   ( spi_sck_i    ),
      .spi_di_i    ( spi_di_i     ),
      .spi_ss_io_i ( conf_data0_i ),
      .spi_ss_dl_i ( spi_ss2_i    ),
      .spi_ev_o    ( spi_ev       ),
      .sel_io_o    ( sel_io       ),
      .sel_dl_o    ( sel_dl       )
   );

   spi_user_io u_user_io (
      .clk_sys     ( clk_sys     ),
      .rst_n_i     ( rst_n_i     ),
      .spi_ev_i    ( spi_ev      ),
      .sel_i       ( sel_io      ),
      .spi_do_o    ( spi_do_o    ),
      .joystick1_o ( joystick1_o ),
      .joystick2_o ( joystick2_o ),
      .status_o    ( status_o    ),
      .vid_cfg_o   ( vid_cfg     )
   );

   spi_rom_loader u_rom_loader (
      .clk_sys       ( clk_sys       ),
      .rst_n_i       ( rst_n_i       ),
      .spi_ev_i      ( spi_ev        ),
      .sel_i         ( sel_dl        ),
      .downloading_o ( downloading_o ),
      .ioctl_addr_o  ( ioctl_addr_o  ),
      .ioctl_data_o  ( ioctl_data_o  ),
      .ioctl_wr_o    ( ioctl_wr_o    )
   );

   video_out_stage u_video (
      .clk_sys ( clk_sys ),
      .rst_n_i ( rst_n_i ),
      .vid_i   ( vid_in  ),
      .cfg_i   ( vid_cfg ),
      .vid_o   ( vid_out )
   );

   sd_audio_dac #(.SIGNED_SND(SIGNED_SND)) u_dac (
      .clk_sys   ( clk_sys   ),
      .rst_n_i   ( rst_n_i   ),
      .snd_i     ( snd_i     ),
      .snd_pwm_o ( snd_pwm_o )
   );

endmodule

`default_nettype wire

//--- verif/mist_base_checker.sv
// mist base checker: watches the DUT outputs, compares them with expected values, counts errors
`default_nettype none
`timescale 1ns/1ps

module mist_base_checker (
   input  wire                       clk_sys,
   input  wire                       rst_n_i,
   input  wire                       ioctl_wr_i,
   input  wire mist_pkg::rom_addr_t  ioctl_addr_i,
   input  wire mist_pkg::byte_t      ioctl_data_i,
   input  wire                       downloading_i,
   input  wire mist_pkg::video_out_t video_i
);

   import mist_pkg::*;

   int        errors = 0;
   int        checks = 0;
   rom_addr_t wr_addr_q[$];   // writes seen since the last clear
   byte_t     wr_data_q[$];

   task automatic report(input string msg);
      errors++;
      $display("ERROR %s at %0t", msg, $time);
   endtask

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAIL %s: got %h, expected %h", name, got, exp);
      end
   endtask

   // log every write strobe as the ROM would see it
   always @(posedge clk_sys) begin
      if (rst_n_i && ioctl_wr_i) begin
         wr_addr_q.push_back(ioctl_addr_i);
         wr_data_q.push_back(ioctl_data_i);
         if (!downloading_i) report("write strobe seen outside a download");
      end
   end

   task automatic clear_writes();
      wr_addr_q.delete();
      wr_data_q.delete();
   endtask

   task automatic check_write(input int idx, input rom_addr_t exp_addr, input byte_t exp_data);
      if (idx >= wr_addr_q.size()) begin
         report($sformatf("write %0d never happened", idx));
      end else begin
         check_val("ioctl_addr_o", wr_addr_q[idx], exp_addr);
         check_val("ioctl_data_o", wr_data_q[idx], exp_data);
      end
   endtask

   task automatic check_video(input video_out_t exp);
      check_val("video_r_o", video_i.r, exp.r);
      check_val("video_g_o", video_i.g, exp.g);
      check_val("video_b_o", video_i.b, exp.b);
      check_val("video_hs_o", video_i.hs, exp.hs);
      check_val("video_vs_o", video_i.vs, exp.vs);
   endtask

endmodule

`default_nettype wire

//--- verif/tb_mist_base.sv
// mist base testbench: reads the record file, drives SPI, video and sound, reports the result
`default_nettype none
`timescale 1ns/1ps

module tb_mist_base;

   import mist_pkg::*;

   logic        clk_sys = 1'b0;
   logic        rst_n;
   rgb4_t       game_r, game_g, game_b;
   logic        hs, vs;
   rgb6_t       dbl_r, dbl_g, dbl_b;
   logic        dbl_hs, dbl_vs;
   logic        spi_di, spi_sck, spi_ss2, conf_data0;
   logic [15:0] snd;
   wire         scan2x_enb, spi_do, snd_pwm, ioctl_wr, downloading;
   wire rgb6_t  video_r, video_g, video_b;
   wire         video_hs, video_vs;
   wire word32_t status, joystick1, joystick2;
   wire rom_addr_t ioctl_addr;
   wire byte_t  ioctl_data;

   logic [31:0] stim [0:255];
   byte_t       tx_buf [0:15];
   logic [15:0] lfsr = 16'd71;
   int          cycles = 0;
   int          limit = 0;

   always #20 clk_sys = ~clk_sys;

   mist_base u_mist_base (
      .clk_sys(clk_sys), .rst_n_i(rst_n),
      .game_r_i(game_r), .game_g_i(game_g), .game_b_i(game_b), .hs_i(hs), .vs_i(vs),
      .scan2x_r_i(dbl_r), .scan2x_g_i(dbl_g), .scan2x_b_i(dbl_b),
      .scan2x_hs_i(dbl_hs), .scan2x_vs_i(dbl_vs), .scan2x_enb_o(scan2x_enb),
      .video_r_o(video_r), .video_g_o(video_g), .video_b_o(video_b),
      .video_hs_o(video_hs), .video_vs_o(video_vs),
      .spi_do_o(spi_do), .spi_di_i(spi_di), .spi_sck_i(spi_sck), .spi_ss2_i(spi_ss2),
      .conf_data0_i(conf_data0), .status_o(status), .joystick1_o(joystick1),
      .joystick2_o(joystick2), .snd_i(snd), .snd_pwm_o(snd_pwm),
      .ioctl_addr_o(ioctl_addr), .ioctl_data_o(ioctl_data), .ioctl_wr_o(ioctl_wr),
      .downloading_o(downloading)
   );

   mist_base_checker u_checker (
      .clk_sys(clk_sys), .rst_n_i(rst_n), .ioctl_wr_i(ioctl_wr), .ioctl_addr_i(ioctl_addr),
      .ioctl_data_i(ioctl_data), .downloading_i(downloading),
      .video_i({video_r, video_g, video_b, video_hs, video_vs})
   );

   always @(posedge clk_sys) begin
      cycles++;
      if (limit > 0 && cycles > limit) begin
         $display("timeout: run still busy after %0d cycles", cycles);
         $display("TESTS FAILED");
         $finish;
      end
   end

   // x^16 + x^15 + x^13 + x^4 + 1
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[14] ^ s[12] ^ s[3]};
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         v = {v[30:0], lfsr[0]};
      end
   endtask

   task automatic apply_reset();
      rst_n = 1'b0;
      repeat (2) @(negedge clk_sys);
      rst_n = 1'b1;
   endtask

   // mode 0 byte with data set while SCK is low and DO sampled before each rise
   task automatic send_byte(input byte_t b, output byte_t do_bits);
      for (int i = 7; i >= 0; i--) begin
         spi_di = b[i];
         repeat (4) @(negedge clk_sys);
         do_bits[i] = spi_do;
         spi_sck = 1'b1;
         repeat (4) @(negedge clk_sys);
         spi_sck = 1'b0;
      end
   endtask

   task automatic spi_xfer(input bit dl, input int n);
      byte_t rx;
      if (dl) spi_ss2 = 1'b0;
      else    conf_data0 = 1'b0;
      repeat (4) @(negedge clk_sys);
      for (int k = 0; k < n; k++) begin
         send_byte(tx_buf[k], rx);
         if (k == 0 && !dl) u_checker.check_val("spi_do_o", rx, CORE_ID);
      end
      repeat (4) @(negedge clk_sys);
      spi_ss2 = 1'b1;
      conf_data0 = 1'b1;
      repeat (8) @(negedge clk_sys);   // let the register or strobe settle
   endtask

   function automatic video_out_t calc_video(input logic [1:0] cfg);
      video_out_t o;
      int r, g, b, t;
      logic sh, sv, cs;
      if (cfg[0]) begin
         r = {game_r, game_r[3:2]};
         g = {game_g, game_g[3:2]};
         b = {game_b, game_b[3:2]};
         sh = !hs;
         sv = !vs;
      end else begin
         r = dbl_r;
         g = dbl_g;
         b = dbl_b;
         sh = dbl_hs;
         sv = dbl_vs;
      end
      cs = !(sh ^ sv);
      o = '{r: r[5:0], g: g[5:0], b: b[5:0], hs: sh, vs: sv};
      if (cfg[1]) begin
         o.g = ((77 * r + 150 * g + 29 * b) / 256) & 63;
         t = -43 * r - 85 * g + 128 * b;
         o.b = (32 + ((t < 0) ? (t - 255) / 256 : t / 256)) & 63;   // floor division
         t = 128 * r - 107 * g - 21 * b;
         o.r = (32 + ((t < 0) ? (t - 255) / 256 : t / 256)) & 63;
      end
      if (cfg != 2'b00) begin
         o.hs = cs;
         o.vs = 1'b1;
      end
      return o;
   endfunction

   function automatic int rec_len(input int pc);
      case (stim[pc])
         1: return 4;
         2: return 4 + stim[pc + 2];
         3, 5: return 3;
         default: return 1;
      endcase
   endfunction

   initial begin
      int pc;
      int ones;
      logic [31:0] v;
      video_out_t exp;
      {game_r, game_g, game_b, hs, vs, dbl_r, dbl_g, dbl_b, dbl_hs, dbl_vs} = '0;
      {spi_di, spi_sck, snd} = '0;
      spi_ss2 = 1'b1;
      conf_data0 = 1'b1;
      rst_n = 1'b0;
      $readmemh("verif/mist_base_stimulus.txt", stim);
      for (pc = 0; stim[pc] !== 32'd0 && pc < 256; pc += rec_len(pc)) limit += rec_len(pc);
      limit = limit * 600;
      apply_reset();
      pc = 0;
      while (stim[pc] !== 32'd0) begin
         case (stim[pc])
            1: begin   // config word or video option
               tx_buf[0] = stim[pc + 1][7:0];
               v = stim[pc + 2];
               if (tx_buf[0] == CMD_VIDCFG) begin
                  tx_buf[1] = v[7:0];
                  spi_xfer(1'b0, 2);
                  u_checker.check_val("scan2x_enb_o", scan2x_enb, stim[pc + 3]);
               end else begin
                  {tx_buf[1], tx_buf[2], tx_buf[3], tx_buf[4]} = v;
                  spi_xfer(1'b0, 5);
                  case (tx_buf[0])
                     CMD_JOY0: u_checker.check_val("joystick1_o", joystick1, stim[pc + 3]);
                     CMD_JOY1: u_checker.check_val("joystick2_o", joystick2, stim[pc + 3]);
                     default:  u_checker.check_val("status_o", status, stim[pc + 3]);
                  endcase
               end
            end
            2: begin   // ROM download
               u_checker.clear_writes();
               if (stim[pc + 1] != 0) begin
                  tx_buf[0] = CMD_DL_START;
                  spi_xfer(1'b1, 1);
               end
               tx_buf[0] = CMD_DL_DATA;
               for (int i = 0; i < stim[pc + 2]; i++) tx_buf[i + 1] = stim[pc + 4 + i][7:0];
               spi_xfer(1'b1, stim[pc + 2] + 1);
               tx_buf[0] = CMD_DL_END;
               spi_xfer(1'b1, 1);
               u_checker.check_val("write count", u_checker.wr_addr_q.size(), stim[pc + 3]);
               for (int i = 0; i < stim[pc + 3]; i++) u_checker.check_write(i, i, stim[pc + 4 + i]);
               u_checker.check_val("downloading_o", downloading, 0);
            end
            3: begin   // random video vectors under one configuration
               tx_buf[0] = CMD_VIDCFG;
               tx_buf[1] = stim[pc + 1][7:0];
               spi_xfer(1'b0, 2);
               for (int i = 0; i < stim[pc + 2]; i++) begin
                  take_bits(14, v);
                  {game_r, game_g, game_b, hs, vs} = v[13:0];
                  take_bits(20, v);
                  {dbl_r, dbl_g, dbl_b, dbl_hs, dbl_vs} = v[19:0];
                  exp = calc_video(stim[pc + 1][1:0]);
                  @(negedge clk_sys);
                  u_checker.check_video(exp);
               end
            end
            5: begin   // DAC density over 256 cycles from reset
               snd = stim[pc + 1][15:0];
               apply_reset();
               ones = 0;
               repeat (256) begin
                  @(negedge clk_sys);
                  ones += snd_pwm;
               end
               u_checker.check_val("snd_pwm_o ones", ones, stim[pc + 2]);
            end
            default: begin
               u_checker.report($sformatf("unknown record opcode %h", stim[pc]));
               break;
            end
         endcase
         pc += rec_len(pc);
      end
      $display("checks: %0d, errors: %0d", u_checker.checks, u_checker.errors);
      if (u_checker.errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- verif/mist_base_stimulus.txt
// config: 1 cmd value expected | download: 2 start count writes bytes...
// video: 3 cfg vectors | dac: 5 sample ones | end: 0
1 01 12345678 12345678
1 02 A5C3F00F A5C3F00F
1 1E 80000001 80000001
1 14 00000001 00000001
1 14 00000002 00000000
2 1 6 6 11 22 33 44 55 66
2 0 3 0 AA BB CC
2 1 4 4 DE AD BE EF
3 0 10
3 1 10
3 2 10
3 3 10
5 0000 00
5 0100 01
5 1234 12
5 8000 80
5 FFFF FF
0

//--- sources.f
source/mist_pkg.sv
source/spi_front.sv
source/spi_user_io.sv
source/spi_rom_loader.sv
source/video_out_stage.sv
source/sd_audio_dac.sv
source/mist_base.sv
verif/mist_base_checker.sv
verif/tb_mist_base.sv

//--- Bender.yml
package:
  name: mist_base

sources:
  - source/mist_pkg.sv
  - source/spi_front.sv
  - source/spi_user_io.sv
  - source/spi_rom_loader.sv
  - source/video_out_stage.sv
  - source/sd_audio_dac.sv
  - source/mist_base.sv
  - target: test
    files:
      - verif/mist_base_checker.sv
      - verif/tb_mist_base.sv
